//--- rtl/cpu_types_pkg.sv
package cpu_types_pkg;

    localparam int xlen = 32;      // data and pc width.
    localparam int reg_addr_w = 5;

    // major opcodes seen at retire.
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_alu    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    // funct3 for system ops, zero means no csr access.
    typedef enum logic [2:0] {
        f_none  = 3'd0,
        f_csrrw = 3'd1,
        f_csrrs = 3'd2
    } funct_e;

    typedef enum logic [11:0] {
        csr_mscratch = 12'h340,
        csr_minstret = 12'hB02
    } csr_addr_e;

    // one retiring instruction.
    typedef struct packed {
        opcode_e                 opcode;
        funct_e                  funct;
        csr_addr_e               csr;
        logic [xlen-1:0]         pc;
        logic [xlen-1:0]         rd_data;   // execute result.
        logic [xlen-1:0]         load_data;
        logic [xlen-1:0]         rs1_data;
        logic [reg_addr_w-1:0]   rd_addr;
        logic                    we_rd;
        logic                    we;        // memory access.
    } retire_t;

    // register file write.
    typedef struct packed {
        logic                    we;
        logic [reg_addr_w-1:0]   addr;
        logic [xlen-1:0]         data;
    } rd_write_t;

endpackage

//--- rtl/axi_lite_pkg.sv
package axi_lite_pkg;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_e;

    // master to slave.
    typedef struct packed {
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic        bready;
    } axi_req_t;

    // slave to master.
    typedef struct packed {
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        resp_e       rresp;
        logic        awready;
        logic        wready;
        logic        bvalid;
        resp_e       bresp;
    } axi_rsp_t;

endpackage

//--- rtl/writeback.sv
`timescale 1ns/10ps

module writeback #(
    parameter logic [cpu_types_pkg::xlen-1:0] reset_pc = 32'h0
) (
    input  logic                              wb_clk,
    input  logic                              wb_rst,
    input  cpu_types_pkg::retire_t            retire_in,
    input  logic [cpu_types_pkg::xlen-1:0]    csr_rdata,
    input  logic                              ce,
    input  logic                              stall_in,
    input  logic                              flush_in,
    output cpu_types_pkg::rd_write_t          wb_out,
    output logic [cpu_types_pkg::xlen-1:0]    next_pc,
    output logic                              change_pc,
    output logic                              we_out,
    output logic                              ce_out,
    output logic                              stall_out,
    output logic                              flush_out
);

    logic is_load;
    logic is_csr;

    assign is_load = (retire_in.opcode == cpu_types_pkg::op_load) && retire_in.we;
    assign is_csr  = (retire_in.opcode == cpu_types_pkg::op_system) &&
                     (retire_in.funct != cpu_types_pkg::f_none);

    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            wb_out    <= '0;
            next_pc   <= reset_pc;
            change_pc <= 1'b0;
            we_out    <= 1'b0;
            ce_out    <= 1'b0;
            stall_out <= 1'b0;
            flush_out <= 1'b0;
        end else if (!flush_in) begin
            // flush freezes the whole stage.
            ce_out <= ce;
            if (ce) begin
                stall_out   <= 1'b0;
                flush_out   <= 1'b0;
                change_pc   <= 1'b0;
                wb_out.we   <= retire_in.we_rd;
                wb_out.addr <= retire_in.rd_addr;
                we_out      <= retire_in.we;
                // load beats csr beats alu.
                if (is_load) begin
                    wb_out.data <= retire_in.load_data;
                end else if (is_csr) begin
                    wb_out.data <= csr_rdata;     // old csr value.
                end else if (retire_in.we_rd) begin
                    wb_out.data <= retire_in.rd_data;
                end
                next_pc <= retire_in.pc + 32'd4;
            end else begin
                wb_out    <= '0;
                stall_out <= stall_in;             // upstream holding.
            end
        end
    end

endmodule

//--- rtl/csr_file.sv
`timescale 1ns/10ps

module csr_file (
    input  logic                              wb_clk,
    input  logic                              wb_rst,
    input  cpu_types_pkg::retire_t            retire_in,
    input  logic                              accept,
    output logic [cpu_types_pkg::xlen-1:0]    csr_rdata
);

    logic [cpu_types_pkg::xlen-1:0] mscratch;
    logic [cpu_types_pkg::xlen-1:0] minstret;
    logic                           csr_write;

    // read side sees state before this instruction.
    always_comb begin
        case (retire_in.csr)
            cpu_types_pkg::csr_mscratch: csr_rdata = mscratch;
            cpu_types_pkg::csr_minstret: csr_rdata = minstret;
            default:                     csr_rdata = '0;
        endcase
    end

    assign csr_write = (retire_in.opcode == cpu_types_pkg::op_system) &&
                       (retire_in.funct == cpu_types_pkg::f_csrrw) &&
                       (retire_in.csr == cpu_types_pkg::csr_mscratch);

    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            mscratch <= '0;
            minstret <= '0;
        end else if (accept) begin
            minstret <= minstret + 32'd1;  // counts every retire.
            if (csr_write) begin
                mscratch <= retire_in.rs1_data;
            end
        end
    end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                                  wb_clk,
    input  logic                                  wb_rst,
    input  cpu_types_pkg::rd_write_t              wr,
    input  logic [cpu_types_pkg::reg_addr_w-1:0]  rd_idx,
    output logic [cpu_types_pkg::xlen-1:0]        rd_val
);

    logic [cpu_types_pkg::xlen-1:0] regs [32];

    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;   // x0 stays zero.
        end
    end

    // debug read.
    assign rd_val = regs[rd_idx];

endmodule

//--- rtl/axi_lite_debug_port.sv
`timescale 1ns/10ps

module axi_lite_debug_port (
    input  logic                                  wb_clk,
    input  logic                                  wb_rst,
    input  axi_lite_pkg::axi_req_t                axi_req,
    output axi_lite_pkg::axi_rsp_t                axi_rsp,
    output logic [cpu_types_pkg::reg_addr_w-1:0]  rd_idx,
    input  logic [cpu_types_pkg::xlen-1:0]        rd_val
);

    typedef enum logic {rd_idle, rd_resp} rd_state_e;
    typedef enum logic {wr_idle, wr_bresp} wr_state_e;

    rd_state_e                      rd_state;
    wr_state_e                      wr_state;
    logic [cpu_types_pkg::xlen-1:0] rdata;
    logic                           ar_hs;
    logic                           aw_hs;

    assign rd_idx = axi_req.araddr[6:2];   // word index.
    assign ar_hs  = axi_req.arvalid && (rd_state == rd_idle);
    assign aw_hs  = axi_req.awvalid && axi_req.wvalid && (wr_state == wr_idle);

    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            rd_state <= rd_idle;
            wr_state <= wr_idle;
        end else begin
            if (ar_hs) begin
                rd_state <= rd_resp;
            end else if ((rd_state == rd_resp) && axi_req.rready) begin
                rd_state <= rd_idle;
            end
            if (aw_hs) begin
                wr_state <= wr_bresp;
            end else if ((wr_state == wr_bresp) && axi_req.bready) begin
                wr_state <= wr_idle;
            end
        end
    end

    always_ff @(posedge wb_clk) begin
        if (ar_hs) begin
            rdata <= rd_val;
        end
    end

    // writes are never taken, only answered.
    assign axi_rsp.arready = (rd_state == rd_idle);
    assign axi_rsp.rvalid  = (rd_state == rd_resp);
    assign axi_rsp.rdata   = rdata;
    assign axi_rsp.rresp   = axi_lite_pkg::resp_okay;
    assign axi_rsp.awready = aw_hs;
    assign axi_rsp.wready  = aw_hs;
    assign axi_rsp.bvalid  = (wr_state == wr_bresp);
    assign axi_rsp.bresp   = axi_lite_pkg::resp_slverr;

endmodule

//--- rtl/wb_backend.sv
`timescale 1ns/10ps

module wb_backend #(
    parameter logic [cpu_types_pkg::xlen-1:0] reset_pc = 32'h0
) (
    input  logic                              wb_clk,
    input  logic                              wb_rst,
    input  cpu_types_pkg::retire_t            retire_in,
    input  logic                              ce,
    input  logic                              stall_in,
    input  logic                              flush_in,
    output cpu_types_pkg::rd_write_t          wb_out,
    output logic [cpu_types_pkg::xlen-1:0]    next_pc,
    output logic                              change_pc,
    output logic                              we_out,
    output logic                              ce_out,
    output logic                              stall_out,
    output logic                              flush_out,
    input  axi_lite_pkg::axi_req_t            axi_req,
    output axi_lite_pkg::axi_rsp_t            axi_rsp
);

    logic [cpu_types_pkg::xlen-1:0]       csr_rdata;
    logic [cpu_types_pkg::reg_addr_w-1:0] dbg_idx;
    logic [cpu_types_pkg::xlen-1:0]       dbg_val;
    logic                                 accept;

    assign accept = ce && !flush_in;

    writeback #(
        .reset_pc(reset_pc)
    ) u_writeback (
        .wb_clk(wb_clk), .wb_rst(wb_rst), .retire_in(retire_in), .csr_rdata(csr_rdata),
        .ce(ce), .stall_in(stall_in), .flush_in(flush_in), .wb_out(wb_out),
        .next_pc(next_pc), .change_pc(change_pc), .we_out(we_out), .ce_out(ce_out),
        .stall_out(stall_out), .flush_out(flush_out)
    );

    csr_file u_csr_file (
        .wb_clk(wb_clk), .wb_rst(wb_rst), .retire_in(retire_in), .accept(accept),
        .csr_rdata(csr_rdata)
    );

    reg_file u_reg_file (
        .wb_clk(wb_clk), .wb_rst(wb_rst), .wr(wb_out), .rd_idx(dbg_idx), .rd_val(dbg_val)
    );

    axi_lite_debug_port u_axi_lite_debug_port (
        .wb_clk(wb_clk), .wb_rst(wb_rst), .axi_req(axi_req), .axi_rsp(axi_rsp),
        .rd_idx(dbg_idx), .rd_val(dbg_val)
    );

endmodule

//--- bench/tb_wb_backend.sv
`timescale 1ns/10ps

module tb_wb_backend;

    localparam logic [31:0] reset_pc = 32'h100;
    localparam int n_retire = 400;
    localparam int n_reads = 40;
    localparam int watchdog_ns = (n_retire + n_reads) * 20 * 4;

    logic                     wb_clk;
    logic                     wb_rst;
    cpu_types_pkg::retire_t   retire_in;
    logic                     ce;
    logic                     stall_in;
    logic                     flush_in;
    cpu_types_pkg::rd_write_t wb_out;
    logic [31:0]              next_pc;
    logic                     change_pc;
    logic                     we_out;
    logic                     ce_out;
    logic                     stall_out;
    logic                     flush_out;
    axi_lite_pkg::axi_req_t   axi_req;
    axi_lite_pkg::axi_rsp_t   axi_rsp;

    // reference model.
    logic [31:0]              m_regs [32];
    logic [31:0]              m_mscratch;
    logic [31:0]              m_minstret;
    cpu_types_pkg::rd_write_t m_wb;
    logic [31:0]              m_next_pc;
    logic                     m_ce_out;
    logic                     m_we_out;
    logic                     m_stall_out;

    int seed = 78442;
    int errors = 0;
    int checks = 0;
    int accepted = 0;

    wb_backend #(
        .reset_pc(reset_pc)
    ) u_wb_backend (
        .wb_clk(wb_clk), .wb_rst(wb_rst), .retire_in(retire_in), .ce(ce),
        .stall_in(stall_in), .flush_in(flush_in), .wb_out(wb_out), .next_pc(next_pc),
        .change_pc(change_pc), .we_out(we_out), .ce_out(ce_out), .stall_out(stall_out),
        .flush_out(flush_out), .axi_req(axi_req), .axi_rsp(axi_rsp)
    );

    always #2 wb_clk = ~wb_clk;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_val("wb_out.we", 32'(wb_out.we), 32'(m_wb.we));
        check_val("wb_out.addr", 32'(wb_out.addr), 32'(m_wb.addr));
        check_val("wb_out.data", wb_out.data, m_wb.data);
        check_val("next_pc", next_pc, m_next_pc);
        check_val("ce_out", 32'(ce_out), 32'(m_ce_out));
        check_val("we_out", 32'(we_out), 32'(m_we_out));
        check_val("stall_out", 32'(stall_out), 32'(m_stall_out));
        check_val("flush_out", 32'(flush_out), 32'h0);
        check_val("change_pc", 32'(change_pc), 32'h0);
    endtask

    // advances the model by one edge with the given inputs.
    task automatic model_step(input cpu_types_pkg::retire_t r, input logic c, input logic s,
                              input logic f);
        logic [31:0] csr_old;
        csr_old = (r.csr == cpu_types_pkg::csr_mscratch) ? m_mscratch : m_minstret;
        if (m_wb.we && (m_wb.addr != 5'd0)) begin
            m_regs[m_wb.addr] = m_wb.data;   // value shown before this edge.
        end
        if (!f && c) begin
            m_ce_out = 1'b1;
            m_stall_out = 1'b0;
            m_wb.we = r.we_rd;
            m_wb.addr = r.rd_addr;
            m_we_out = r.we;
            if ((r.opcode == cpu_types_pkg::op_load) && r.we) begin
                m_wb.data = r.load_data;
            end else if ((r.opcode == cpu_types_pkg::op_system) &&
                         (r.funct != cpu_types_pkg::f_none)) begin
                m_wb.data = csr_old;
            end else if (r.we_rd) begin
                m_wb.data = r.rd_data;
            end
            m_next_pc = r.pc + 32'd4;
            if ((r.opcode == cpu_types_pkg::op_system) && (r.funct == cpu_types_pkg::f_csrrw) &&
                (r.csr == cpu_types_pkg::csr_mscratch)) begin
                m_mscratch = r.rs1_data;
            end
            m_minstret = m_minstret + 32'd1;
        end else if (!f) begin
            m_ce_out = 1'b0;
            m_wb = '0;
            m_stall_out = s;
        end
    endtask

    task automatic drive_cycle(input cpu_types_pkg::retire_t r, input logic c, input logic s,
                               input logic f);
        @(posedge wb_clk);
        retire_in <= r;
        ce <= c;
        stall_in <= s;
        flush_in <= f;
        @(negedge wb_clk);
        check_outputs();
        model_step(r, c, s, f);
        if (c && !f) begin
            accepted++;
        end
    endtask

    task automatic make_retire(output cpu_types_pkg::retire_t r);
        logic [31:0] v;
        v = $random(seed);
        case (v[1:0])
            2'd0: r.opcode = cpu_types_pkg::op_load;
            2'd1: r.opcode = cpu_types_pkg::op_system;
            2'd2: r.opcode = cpu_types_pkg::op_alu;
            default: r.opcode = cpu_types_pkg::op_store;
        endcase
        case (v[3:2])
            2'd0: r.funct = cpu_types_pkg::f_none;
            2'd1: r.funct = cpu_types_pkg::f_csrrw;
            default: r.funct = cpu_types_pkg::f_csrrs;
        endcase
        r.csr = v[4] ? cpu_types_pkg::csr_minstret : cpu_types_pkg::csr_mscratch;
        r.rd_addr = v[9:5];
        r.we_rd = v[10];
        r.we = v[11];
        r.pc = $random(seed);
        r.rd_data = $random(seed);
        r.load_data = $random(seed);
        r.rs1_data = $random(seed);
    endtask

    task automatic axi_read(input logic [4:0] idx, output logic [31:0] data,
                            output axi_lite_pkg::resp_e resp);
        logic [31:0] v;
        v = $random(seed);
        @(posedge wb_clk);
        axi_req.arvalid <= 1'b1;
        axi_req.araddr <= {25'd0, idx, 2'b00};
        @(negedge wb_clk);
        while (!axi_rsp.arready) @(negedge wb_clk);
        @(posedge wb_clk);
        axi_req.arvalid <= 1'b0;                     // ar taken here.
        @(negedge wb_clk);
        while (!axi_rsp.rvalid) @(negedge wb_clk);
        repeat (int'(v[1:0])) @(negedge wb_clk);      // master not ready yet.
        check_val("axi_rsp.rvalid", 32'(axi_rsp.rvalid), 32'h1);
        data = axi_rsp.rdata;
        resp = axi_rsp.rresp;
        @(posedge wb_clk);
        axi_req.rready <= 1'b1;
        @(posedge wb_clk);
        axi_req.rready <= 1'b0;
    endtask

    task automatic axi_write(input logic [4:0] idx, input logic [31:0] val,
                             output axi_lite_pkg::resp_e resp);
        @(posedge wb_clk);
        axi_req.awvalid <= 1'b1;
        axi_req.wvalid <= 1'b1;
        axi_req.awaddr <= {25'd0, idx, 2'b00};
        axi_req.wdata <= val;
        @(negedge wb_clk);
        while (!axi_rsp.awready) @(negedge wb_clk);
        check_val("axi_rsp.wready", 32'(axi_rsp.wready), 32'h1);   // taken with aw.
        @(posedge wb_clk);
        axi_req.awvalid <= 1'b0;
        axi_req.wvalid <= 1'b0;
        @(negedge wb_clk);
        while (!axi_rsp.bvalid) @(negedge wb_clk);
        resp = axi_rsp.bresp;
        @(posedge wb_clk);
        axi_req.bready <= 1'b1;
        @(posedge wb_clk);
        axi_req.bready <= 1'b0;
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: run did not finish within %0d ns", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        cpu_types_pkg::retire_t r;
        cpu_types_pkg::retire_t idle;
        axi_lite_pkg::resp_e    resp;
        logic [31:0]            v;
        logic [31:0]            data;
        logic [31:0]            old_val;
        logic [4:0]             idx;
        int                     count_before;
        wb_clk = 1'b0;
        wb_rst = 1'b0;
        retire_in = '0;
        ce = 1'b0;
        stall_in = 1'b0;
        flush_in = 1'b0;
        axi_req = '0;
        idle = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_mscratch = '0;
        m_minstret = '0;
        m_wb = '0;
        m_next_pc = reset_pc;
        m_ce_out = 1'b0;
        m_we_out = 1'b0;
        m_stall_out = 1'b0;
        repeat (10) @(posedge wb_clk);
        wb_rst <= 1'b1;

        @(negedge wb_clk);
        check_outputs();
        check_val("next_pc", next_pc, 32'h100);
        check_val("axi_rsp.rvalid", 32'(axi_rsp.rvalid), 32'h0);
        check_val("axi_rsp.bvalid", 32'(axi_rsp.bvalid), 32'h0);
        repeat (3) begin
            v = $random(seed);
            axi_read(v[4:0], data, resp);
            check_val("axi_rsp.rdata", data, 32'h0);
        end

        // random stream with idle and flushed cycles mixed in.
        for (int i = 0; i < n_retire; i++) begin
            v = $random(seed);
            if (v[1:0] == 2'd0) begin
                drive_cycle(idle, 1'b0, v[2], 1'b0);
            end
            if (v[5:3] == 3'd0) begin
                make_retire(r);
                drive_cycle(r, v[6], 1'b0, 1'b1);   // lost to the flush.
            end
            make_retire(r);
            drive_cycle(r, 1'b1, 1'b0, 1'b0);
        end

        r = '0;
        r.opcode = cpu_types_pkg::op_system;
        r.funct = cpu_types_pkg::f_csrrw;
        r.csr = cpu_types_pkg::csr_mscratch;
        r.rd_addr = 5'd7;
        r.we_rd = 1'b1;
        r.rs1_data = 32'hA5A5_0001;
        old_val = m_mscratch;
        drive_cycle(r, 1'b1, 1'b0, 1'b0);
        r.funct = cpu_types_pkg::f_csrrs;
        r.rd_addr = 5'd8;
        r.rs1_data = '0;
        drive_cycle(r, 1'b1, 1'b0, 1'b0);
        check_val("csrrw wb_out.data", wb_out.data, old_val);
        r.csr = cpu_types_pkg::csr_minstret;
        r.rd_addr = 5'd9;
        count_before = accepted;
        drive_cycle(r, 1'b1, 1'b0, 1'b0);
        check_val("csrrs mscratch wb_out.data", wb_out.data, 32'hA5A5_0001);
        drive_cycle(idle, 1'b0, 1'b0, 1'b0);
        check_val("csrrs minstret wb_out.data", wb_out.data, 32'(count_before));
        repeat (3) drive_cycle(idle, 1'b0, 1'b0, 1'b0);

        for (int i = 0; i < 32; i++) begin
            axi_read(5'(i), data, resp);
            check_val($sformatf("axi_rsp.rdata x%0d", i), data, m_regs[i]);
            check_val("axi_rsp.rresp", 32'(resp), 32'(axi_lite_pkg::resp_okay));
            if (i == 0) begin
                check_val("axi_rsp.rdata x0", data, 32'h0);
            end
        end

        v = $random(seed);
        idx = (v[4:0] == 5'd0) ? 5'd1 : v[4:0];
        axi_write(idx, ~m_regs[idx], resp);
        check_val("axi_rsp.bresp", 32'(resp), 32'(axi_lite_pkg::resp_slverr));
        axi_read(idx, data, resp);
        check_val("axi_rsp.rdata after write", data, m_regs[idx]);

        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/cpu_types_pkg.sv
rtl/axi_lite_pkg.sv
rtl/writeback.sv
rtl/csr_file.sv
rtl/reg_file.sv
rtl/axi_lite_debug_port.sv
rtl/wb_backend.sv
bench/tb_wb_backend.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_wb_backend
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/10ps
VFLAGS     ?= --binary --assert --timing
LINT_FLAGS ?= -Wall --timing
PASS_MSG   ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
